// File: cpuCore.f
source/cpuPkg.sv
source/alu.sv
source/regFile.sv
source/instrDecoder.sv
source/unifiedMemory.sv
source/cpuFsm.sv
source/cpuCore.sv
tb/cpuCore_properties.sv
tb/cpuCoreTb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module cpuCoreTb -f cpuCore.f -Mdir obj_dir \
	|| { echo "build failed"; exit 1; }
./obj_dir/VcpuCoreTb > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
echo "simulation finished without failure"
exit 0

// File: tb/cpuCoreTb.sv
`timescale 1ns/1ns

module cpuCoreTb;

	localparam int RUNS        = 14;
	localparam int CYCLE_LIMIT = 2 * RUNS * (2 * cpuPkg::MEM_DEPTH + 220); // Load, readback, run

	logic         clk;
	logic         reset;
	logic         run;
	logic         hostWrite;
	cpuPkg::addrT hostAddr;
	cpuPkg::wordT hostWriteData;
	cpuPkg::wordT hostReadData;
	logic         halted;

	cpuPkg::wordT progImage [cpuPkg::MEM_DEPTH];
	cpuPkg::wordT expImage [cpuPkg::MEM_DEPTH];
	int           progLen;
	logic [15:0]  lfsrState;
	event         compareNow;
	event         compareDone;

	cpuCore cpuCore_inst (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stopWithFailure();
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at first failure");
	endtask

	function automatic logic [15:0] randomBits(int nBits);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < nBits; i++) begin
			value     = {value[14:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
		end
		return value;
	endfunction

	function automatic cpuPkg::wordT instr(cpuPkg::opcodeT op, cpuPkg::regIdxT rd, logic [7:0] low);
		return {op, rd, low};
	endfunction

	function automatic void emit(cpuPkg::wordT word);
		progImage[cpuPkg::addrT'(progLen)] = word;
		progLen++;
	endfunction

	function automatic void startProgram();
		for (int a = 0; a < cpuPkg::MEM_DEPTH; a++)
			progImage[a] = {cpuPkg::addrT'(a) ^ 8'h5A, cpuPkg::addrT'(a)}; // Fill tied to address
		progLen = 0;
	endfunction

	function automatic void storeRange(int lastReg, logic [7:0] base);
		for (int i = 0; i <= lastReg; i++) begin
			emit(instr(cpuPkg::OP_MOVI, 4'd15, base + 8'(i))); // r15 holds the address
			emit(instr(cpuPkg::OP_STORE, cpuPkg::regIdxT'(i), 8'hF0));
		end
	endfunction

	function automatic void buildAluProgram();
		startProgram();
		emit(instr(cpuPkg::OP_MOVI, 4'd1, 8'hFF));
		emit(instr(cpuPkg::OP_MOVI, 4'd2, 8'h01));
		emit(instr(cpuPkg::OP_ADD, 4'd1, 8'h20)); // r1 += r2
		emit(instr(cpuPkg::OP_ADDI, 4'd3, 8'hFF)); // r3 = FFFF
		emit(instr(cpuPkg::OP_ADDI, 4'd3, 8'h02)); // Wraps to 0001
		emit(instr(cpuPkg::OP_MOVI, 4'd4, 8'hC3));
		emit(instr(cpuPkg::OP_SUB, 4'd4, 8'h10));
		emit(instr(cpuPkg::OP_MOVI, 4'd5, 8'h3C));
		emit(instr(cpuPkg::OP_AND, 4'd5, 8'h40));
		emit(instr(cpuPkg::OP_MOVI, 4'd6, 8'h81));
		emit(instr(cpuPkg::OP_OR, 4'd6, 8'h40));
		emit(instr(cpuPkg::OP_MOVI, 4'd7, 8'h5A));
		emit(instr(cpuPkg::OP_XOR, 4'd7, 8'h10));
		emit(instr(cpuPkg::OP_ADDI, 4'd8, 8'hFF));
		emit(instr(cpuPkg::OP_ADD, 4'd8, 8'h20)); // Carry out dropped, result zero
		storeRange(8, 8'h80);
		emit(instr(cpuPkg::OP_HALT, 4'd0, 8'h00));
	endfunction

	// Memory round trips first, then branch and jump paths
	function automatic void buildFlowProgram();
		startProgram();
		emit(instr(cpuPkg::OP_MOVI, 4'd1, 8'h5A));
		emit(instr(cpuPkg::OP_ADDI, 4'd1, 8'h80)); // Negative value
		emit(instr(cpuPkg::OP_MOVI, 4'd2, 8'hA0));
		emit(instr(cpuPkg::OP_STORE, 4'd1, 8'h20));
		emit(instr(cpuPkg::OP_LOAD, 4'd4, 8'h20));
		emit(instr(cpuPkg::OP_MOVI, 4'd5, 8'hC3));
		emit(instr(cpuPkg::OP_LOAD, 4'd6, 8'h50)); // Host fill word
		emit(instr(cpuPkg::OP_SUB, 4'd7, 8'h70)); // Zero flag set
		emit(instr(cpuPkg::OP_LOAD, 4'd8, 8'h20)); // Flags must survive this
		emit(instr(cpuPkg::OP_BZ, 4'd0, 8'h01));
		emit(instr(cpuPkg::OP_MOVI, 4'd9, 8'h11)); // Skipped
		emit(instr(cpuPkg::OP_ADDI, 4'd3, 8'hFD)); // r3 = -3
		emit(instr(cpuPkg::OP_ADDI, 4'd3, 8'h01)); // Loop top at 12
		emit(instr(cpuPkg::OP_BN, 4'd0, 8'hFE));
		emit(instr(cpuPkg::OP_BN, 4'd0, 8'h05)); // Not taken
		emit(instr(cpuPkg::OP_BZ, 4'd0, 8'h01));
		emit(instr(cpuPkg::OP_MOVI, 4'd9, 8'hEE)); // Skipped
		emit(instr(cpuPkg::OP_MOVI, 4'd10, 8'd20));
		emit(instr(cpuPkg::OP_JUMP, 4'd0, 8'hA0));
		emit(instr(cpuPkg::OP_MOVI, 4'd9, 8'hDD)); // Jumped over
		emit(instr(cpuPkg::OP_ADDI, 4'd3, 8'h01));
		emit(instr(cpuPkg::OP_BZ, 4'd0, 8'hF0)); // Not taken
		emit(instr(cpuPkg::OP_MOVI, 4'd11, 8'h77));
		storeRange(11, 8'hA1);
		emit(instr(cpuPkg::OP_HALT, 4'd0, 8'h00));
	endfunction

	function automatic void buildRandomProgram();
		logic [15:0] draw;
		startProgram();
		for (int i = 0; i < 20; i++) begin
			draw = randomBits(3);
			emit({cpuPkg::opcodeT'(draw % 16'd7), cpuPkg::regIdxT'(randomBits(4)),
			      8'(randomBits(8))});
		end
		storeRange(15, 8'h80);
		emit(instr(cpuPkg::OP_HALT, 4'd0, 8'h00));
	endfunction

	// ISA interpreter, leaves the final image in expImage
	function automatic int runReference();
		cpuPkg::wordT regs [cpuPkg::NUM_REGS];
		cpuPkg::wordT ins;
		cpuPkg::wordT res;
		cpuPkg::addrT pc;
		logic         zf;
		logic         nf;
		logic         done;
		int           cycles;
		int           steps;
		expImage = progImage;
		regs     = '{default: '0};
		pc       = '0;
		zf       = 1'b0;
		nf       = 1'b0;
		done     = 1'b0;
		cycles   = 1; // Idle to Fetch
		steps    = 0;
		while (!done && steps < 4096) begin
			ins = expImage[pc];
			pc  = pc + 8'd1;
			res = regs[ins[11:8]];
			steps++;
			case (ins[15:12])
				cpuPkg::OP_ADD:   res = res + regs[ins[7:4]];
				cpuPkg::OP_SUB:   res = res - regs[ins[7:4]];
				cpuPkg::OP_AND:   res = res & regs[ins[7:4]];
				cpuPkg::OP_OR:    res = res | regs[ins[7:4]];
				cpuPkg::OP_XOR:   res = res ^ regs[ins[7:4]];
				cpuPkg::OP_MOVI:  res = {8'h00, ins[7:0]};
				cpuPkg::OP_ADDI:  res = res + {{8{ins[7]}}, ins[7:0]};
				cpuPkg::OP_STORE: expImage[regs[ins[7:4]][7:0]] = regs[ins[11:8]];
				cpuPkg::OP_LOAD:  res = expImage[regs[ins[7:4]][7:0]];
				cpuPkg::OP_JUMP:  pc = regs[ins[7:4]][7:0];
				cpuPkg::OP_BZ:    if (zf) pc = pc + ins[7:0];
				cpuPkg::OP_BN:    if (nf) pc = pc + ins[7:0];
				cpuPkg::OP_HALT:  done = 1'b1;
				default: ;
			endcase
			if (ins[15:12] <= cpuPkg::OP_ADDI) begin
				regs[ins[11:8]] = res;
				zf              = (res == '0);
				nf              = res[15];
				cycles += 3;
			end else if (ins[15:12] == cpuPkg::OP_LOAD) begin
				regs[ins[11:8]] = res;
				cycles += 4;
			end else if (ins[15:12] == cpuPkg::OP_STORE)
				cycles += 4;
			else if (ins[15:12] inside {cpuPkg::OP_JUMP, cpuPkg::OP_BZ, cpuPkg::OP_BN})
				cycles += 3;
			else
				cycles += 2; // HALT and no-op
		end
		return cycles;
	endfunction

	task automatic applyReset();
		@(posedge clk);
		#1 reset = 1'b0;
		run = 1'b0;
		hostWrite = 1'b0;
		#1 assert (!halted) else begin
			$display("halted did not drop when reset was asserted");
			stopWithFailure();
		end
		repeat (5) @(posedge clk);
		#1 reset = 1'b1;
	endtask

	task automatic loadImage();
		for (int a = 0; a < cpuPkg::MEM_DEPTH; a++) begin
			@(posedge clk);
			#1 hostWrite = 1'b1;
			hostAddr = cpuPkg::addrT'(a);
			hostWriteData = progImage[a];
		end
		@(posedge clk);
		#1 hostWrite = 1'b0;
	endtask

	task automatic hostRead(input cpuPkg::addrT addr, output cpuPkg::wordT data);
		@(posedge clk);
		#1 hostAddr = addr;
		#1 data = hostReadData;
	endtask

	task automatic runAndCompare();
		int expCycles;
		int cycles;
		expCycles = runReference();
		@(posedge clk);
		#1 run = 1'b1;
		cycles = 0;
		do begin
			@(posedge clk);
			#1;
			cycles++;
		end while (!halted);
		run = 1'b0;
		assert (cycles == expCycles) else begin
			$display("error: cycles expected %h got %h", expCycles, cycles);
			stopWithFailure();
		end
		-> compareNow;
		@(compareDone);
	endtask

	task automatic checkProgram();
		applyReset();
		loadImage();
		runAndCompare();
	endtask

	task automatic resetMidRun();
		cpuPkg::wordT word;
		buildAluProgram();
		applyReset();
		loadImage();
		@(posedge clk);
		#1 run = 1'b1;
		repeat (runReference() / 2) @(posedge clk);
		#1 reset = 1'b0;
		run = 1'b0;
		repeat (5) @(posedge clk);
		#1 reset = 1'b1;
		repeat (3) @(posedge clk);
		#1 assert (cpuCore_inst.fsm_inst.state == cpuPkg::Idle && !halted) else begin
			$display("core did not return to Idle after reset");
			stopWithFailure();
		end
		for (int a = 0; a < progLen; a++) begin
			hostRead(cpuPkg::addrT'(a), word);
			assert (word == progImage[a]) else begin
				$display("error: hostReadData addr %h expected %h got %h", a[7:0], progImage[a], word);
				stopWithFailure();
			end
		end
		runAndCompare();
	endtask

	initial begin : compareProcess
		cpuPkg::wordT word;
		forever begin
			@(compareNow);
			for (int a = 0; a < cpuPkg::MEM_DEPTH; a++) begin
				hostRead(cpuPkg::addrT'(a), word);
				assert (word == expImage[a]) else begin
					$display("error: hostReadData addr %h expected %h got %h", a[7:0], expImage[a], word);
					stopWithFailure();
				end
			end
			assert (halted) else begin
				$display("halted dropped before reset");
				stopWithFailure();
			end
			-> compareDone;
		end
	end

	initial begin
		repeat (CYCLE_LIMIT) @(posedge clk);
		$display("timeout: core never halted");
		stopWithFailure();
	end

	initial begin
		reset         = 1'b0;
		run           = 1'b0;
		hostWrite     = 1'b0;
		hostAddr      = '0;
		hostWriteData = '0;
		lfsrState     = 16'd50052;
		buildAluProgram();
		checkProgram();
		buildFlowProgram();
		checkProgram();
		repeat (10) begin
			buildRandomProgram();
			checkProgram();
		end
		resetMidRun();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: tb/cpuCore_properties.sv
`timescale 1ns/1ns

module cpuCore_properties (
	input logic             clk,
	input logic             reset,
	input cpuPkg::fsmStateT state,
	input logic             pcEnable,
	input logic             irEnable,
	input logic             regWrite,
	input logic             aluToBus,
	input logic             regRead,
	input logic             memWrite,
	input logic             flagsEnable,
	input logic             pcLoad,
	input logic             halted
);

	irSingleCycle: assert property (@(posedge clk) disable iff (!reset) irEnable |=> !irEnable)
		else $error("irEnable high for more than one cycle");
	noWriteClash: assert property (@(posedge clk) disable iff (!reset) !(memWrite && regWrite))
		else $error("memWrite and regWrite high together");
	haltedHolds: assert property (@(posedge clk) disable iff (!reset) halted |=> halted)
		else $error("halted dropped without reset");
	idleQuiet: assert property (@(posedge clk) disable iff (!reset) (state == cpuPkg::Idle) |->
		!(pcEnable || irEnable || regWrite || aluToBus || regRead || memWrite ||
		  flagsEnable || pcLoad || halted))
		else $error("enable active in Idle");

endmodule

bind cpuFsm cpuCore_properties fsmProps_inst (.*);

// File: source/cpuCore.sv
`timescale 1ns/1ns

module cpuCore (
	input  logic         clk,
	input  logic         reset,
	input  logic         run,
	input  logic         hostWrite,
	input  cpuPkg::addrT hostAddr,
	input  cpuPkg::wordT hostWriteData,
	output cpuPkg::wordT hostReadData,
	output logic         halted
);

	cpuPkg::addrT      pc;
	cpuPkg::wordT      ir;
	logic              zeroFlag;
	logic              negFlag;

	logic              pcEnable;
	logic              irEnable;
	logic              regWrite;
	logic              aluToBus;
	logic              regRead;
	logic              memWrite;
	logic              flagsEnable;
	logic              pcLoad;

	cpuPkg::instrTypeT instrType;
	cpuPkg::aluOpT     aluOp;
	logic              useImm;
	cpuPkg::wordT      immValue;
	cpuPkg::regIdxT    rd;
	cpuPkg::regIdxT    rs;
	logic              branchTaken;

	cpuPkg::wordT      rdValue;
	cpuPkg::wordT      rsValue;
	cpuPkg::wordT      aluOpB;
	cpuPkg::wordT      aluResult;
	logic              aluZero;
	logic              aluNeg;
	cpuPkg::wordT      writeBack;
	cpuPkg::addrT      coreAddr;
	cpuPkg::wordT      coreReadData;
	cpuPkg::addrT      pcTarget;

	assign aluOpB    = useImm ? immValue : rsValue;
	assign writeBack = aluToBus ? aluResult : coreReadData; // Load data otherwise
	assign coreAddr  = regRead ? rsValue[cpuPkg::ADDR_W-1:0] : pc;

	// PC already points past the branch when Branch runs
	assign pcTarget = (instrType == cpuPkg::TYPE_JUMP) ? rsValue[cpuPkg::ADDR_W-1:0]
	                                                   : pc + immValue[cpuPkg::ADDR_W-1:0];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc       <= '0;
			ir       <= '0;
			zeroFlag <= 1'b0;
			negFlag  <= 1'b0;
		end else begin
			if (pcLoad)
				pc <= pcTarget;
			else if (pcEnable)
				pc <= pc + 1'b1;
			if (irEnable)
				ir <= coreReadData;
			if (flagsEnable) begin
				zeroFlag <= aluZero;
				negFlag  <= aluNeg;
			end
		end
	end

	cpuFsm fsm_inst (
		.clk(clk), .reset(reset), .run(run),
		.instrType(instrType), .branchTaken(branchTaken),
		.pcEnable(pcEnable), .irEnable(irEnable), .regWrite(regWrite),
		.aluToBus(aluToBus), .regRead(regRead), .memWrite(memWrite),
		.flagsEnable(flagsEnable), .pcLoad(pcLoad), .halted(halted)
	);

	instrDecoder decoder_inst (
		.instr(ir), .zeroFlag(zeroFlag), .negFlag(negFlag),
		.instrType(instrType), .aluOp(aluOp), .useImm(useImm),
		.immValue(immValue), .rd(rd), .rs(rs), .branchTaken(branchTaken)
	);

	regFile regs_inst (
		.clk(clk), .reset(reset), .writeEnable(regWrite),
		.writeIdx(rd), .readIdxA(rd), .readIdxB(rs),
		.writeData(writeBack), .readDataA(rdValue), .readDataB(rsValue)
	);

	alu alu_inst (
		.opA(rdValue), .opB(aluOpB), .aluOp(aluOp),
		.result(aluResult), .zero(aluZero), .negative(aluNeg)
	);

	unifiedMemory mem_inst (
		.clk(clk),
		.coreAddr(coreAddr), .coreWrite(memWrite), .coreWriteData(rdValue),
		.coreReadData(coreReadData),
		.hostAddr(hostAddr), .hostWrite(hostWrite), .hostWriteData(hostWriteData),
		.hostReadData(hostReadData)
	);

endmodule

// File: source/cpuFsm.sv
`timescale 1ns/1ns

module cpuFsm (
	input  logic               clk,
	input  logic               reset,
	input  logic               run,
	input  cpuPkg::instrTypeT  instrType,
	input  logic               branchTaken,
	output logic               pcEnable,
	output logic               irEnable,
	output logic               regWrite,
	output logic               aluToBus,
	output logic               regRead,
	output logic               memWrite,
	output logic               flagsEnable,
	output logic               pcLoad,
	output logic               halted
);

	cpuPkg::fsmStateT state;
	cpuPkg::fsmStateT nextState;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			state <= cpuPkg::Idle;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			cpuPkg::Idle:   if (run) nextState = cpuPkg::Fetch;
			cpuPkg::Fetch:  nextState = cpuPkg::Decode;
			cpuPkg::Decode: begin
				case (instrType)
					cpuPkg::TYPE_RTYPE:  nextState = cpuPkg::Execute;
					cpuPkg::TYPE_STORE:  nextState = cpuPkg::Store;
					cpuPkg::TYPE_LOAD:   nextState = cpuPkg::Load;
					cpuPkg::TYPE_JUMP:   nextState = cpuPkg::Jump;
					cpuPkg::TYPE_BRANCH: nextState = cpuPkg::Branch;
					cpuPkg::TYPE_HALT:   nextState = cpuPkg::Halt;
					default:             nextState = cpuPkg::Fetch; // No-op goes straight back
				endcase
			end
			cpuPkg::Store:     nextState = cpuPkg::StoreHold;
			cpuPkg::Load:      nextState = cpuPkg::LoadWrite;
			cpuPkg::Halt:      nextState = cpuPkg::Halt; // Only reset leaves
			default:           nextState = cpuPkg::Fetch;
		endcase
	end

	// Enables come from the state, pcLoad in Branch also from the condition
	always_comb begin
		pcEnable    = 1'b0;
		irEnable    = 1'b0;
		regWrite    = 1'b0;
		aluToBus    = 1'b0;
		regRead     = 1'b0;
		memWrite    = 1'b0;
		flagsEnable = 1'b0;
		pcLoad      = 1'b0;
		halted      = 1'b0;
		case (state)
			cpuPkg::Fetch:     irEnable = 1'b1;
			cpuPkg::Decode:    pcEnable = 1'b1;
			cpuPkg::Execute: begin
				regWrite    = 1'b1;
				aluToBus    = 1'b1;
				flagsEnable = 1'b1;
			end
			cpuPkg::Store: begin
				regRead  = 1'b1;
				memWrite = 1'b1;
			end
			cpuPkg::Load:      regRead = 1'b1;
			cpuPkg::LoadWrite: begin
				regRead  = 1'b1; // Address held so read data stays valid
				regWrite = 1'b1;
			end
			cpuPkg::Jump:      pcLoad = 1'b1;
			cpuPkg::Branch:    pcLoad = branchTaken;
			cpuPkg::Halt:      halted = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: source/unifiedMemory.sv
`timescale 1ns/1ns

module unifiedMemory (
	input  logic         clk,
	input  cpuPkg::addrT coreAddr,
	input  logic         coreWrite,
	input  cpuPkg::wordT coreWriteData,
	output cpuPkg::wordT coreReadData,
	input  cpuPkg::addrT hostAddr,
	input  logic         hostWrite,
	input  cpuPkg::wordT hostWriteData,
	output cpuPkg::wordT hostReadData
);

	cpuPkg::wordT mem [cpuPkg::MEM_DEPTH];

	// Host write comes last so it wins on a shared address
	always_ff @(posedge clk) begin
		if (coreWrite)
			mem[coreAddr] <= coreWriteData;
		if (hostWrite)
			mem[hostAddr] <= hostWriteData;
	end

	assign coreReadData = mem[coreAddr];
	assign hostReadData = mem[hostAddr];

endmodule

// File: source/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder (
	input  cpuPkg::wordT      instr,
	input  logic              zeroFlag,
	input  logic              negFlag,
	output cpuPkg::instrTypeT instrType,
	output cpuPkg::aluOpT     aluOp,
	output logic              useImm,
	output cpuPkg::wordT      immValue,
	output cpuPkg::regIdxT    rd,
	output cpuPkg::regIdxT    rs,
	output logic              branchTaken
);

	cpuPkg::opcodeT opcode;
	logic [7:0]     imm8;

	assign opcode = instr[15:12];
	assign rd     = instr[11:8];
	assign rs     = instr[7:4];
	assign imm8   = instr[7:0];

	// MOVI zero-extends, everything else sign-extends
	assign immValue = (opcode == cpuPkg::OP_MOVI) ? {8'h00, imm8} : {{8{imm8[7]}}, imm8};
	assign useImm   = (opcode == cpuPkg::OP_MOVI) || (opcode == cpuPkg::OP_ADDI);

	always_comb begin
		instrType   = cpuPkg::TYPE_NOP;
		branchTaken = 1'b0;
		case (opcode)
			cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_AND, cpuPkg::OP_OR,
			cpuPkg::OP_XOR, cpuPkg::OP_MOVI, cpuPkg::OP_ADDI:
				instrType = cpuPkg::TYPE_RTYPE;
			cpuPkg::OP_STORE: instrType = cpuPkg::TYPE_STORE;
			cpuPkg::OP_LOAD:  instrType = cpuPkg::TYPE_LOAD;
			cpuPkg::OP_JUMP:  instrType = cpuPkg::TYPE_JUMP;
			cpuPkg::OP_BZ: begin
				instrType   = cpuPkg::TYPE_BRANCH;
				branchTaken = zeroFlag;
			end
			cpuPkg::OP_BN: begin
				instrType   = cpuPkg::TYPE_BRANCH;
				branchTaken = negFlag;
			end
			cpuPkg::OP_HALT:  instrType = cpuPkg::TYPE_HALT;
			default: ; // Unused opcodes fall through as no-op
		endcase
	end

	// ADD and ADDI share the adder
	always_comb begin
		case (opcode)
			cpuPkg::OP_SUB:  aluOp = cpuPkg::ALU_SUB;
			cpuPkg::OP_AND:  aluOp = cpuPkg::ALU_AND;
			cpuPkg::OP_OR:   aluOp = cpuPkg::ALU_OR;
			cpuPkg::OP_XOR:  aluOp = cpuPkg::ALU_XOR;
			cpuPkg::OP_MOVI: aluOp = cpuPkg::ALU_PASSB;
			default:         aluOp = cpuPkg::ALU_ADD;
		endcase
	end

endmodule

// File: source/regFile.sv
`timescale 1ns/1ns

module regFile (
	input  logic           clk,
	input  logic           reset,
	input  logic           writeEnable,
	input  cpuPkg::regIdxT writeIdx,
	input  cpuPkg::regIdxT readIdxA,
	input  cpuPkg::regIdxT readIdxB,
	input  cpuPkg::wordT   writeData,
	output cpuPkg::wordT   readDataA,
	output cpuPkg::wordT   readDataB
);

	cpuPkg::wordT regs [cpuPkg::NUM_REGS];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < cpuPkg::NUM_REGS; i++)
				regs[i] <= '0;
		end else if (writeEnable) begin
			regs[writeIdx] <= writeData;
		end
	end

	// Combinational reads, a write shows up next cycle
	assign readDataA = regs[readIdxA];
	assign readDataB = regs[readIdxB];

endmodule

// File: source/alu.sv
`timescale 1ns/1ns

module alu (
	input  cpuPkg::wordT  opA,
	input  cpuPkg::wordT  opB,
	input  cpuPkg::aluOpT aluOp,
	output cpuPkg::wordT  result,
	output logic          zero,
	output logic          negative
);

	always_comb begin
		case (aluOp)
			cpuPkg::ALU_ADD:   result = opA + opB; // Carry out dropped
			cpuPkg::ALU_SUB:   result = opA - opB;
			cpuPkg::ALU_AND:   result = opA & opB;
			cpuPkg::ALU_OR:    result = opA | opB;
			cpuPkg::ALU_XOR:   result = opA ^ opB;
			cpuPkg::ALU_PASSB: result = opB;
			default:           result = '0;
		endcase
	end

	assign zero     = (result == '0);
	assign negative = result[cpuPkg::WORD_W-1]; // Sign bit of the result

endmodule

// File: source/cpuPkg.sv
package cpuPkg;

	localparam int WORD_W    = 16;
	localparam int ADDR_W    = 8;
	localparam int REG_IDX_W = 4;
	localparam int MEM_DEPTH = 1 << ADDR_W;
	localparam int NUM_REGS  = 1 << REG_IDX_W;

	typedef logic [WORD_W-1:0]    wordT;
	typedef logic [ADDR_W-1:0]    addrT;
	typedef logic [REG_IDX_W-1:0] regIdxT;
	typedef logic [3:0]           opcodeT;
	typedef logic [2:0]           instrTypeT;
	typedef logic [2:0]           aluOpT;

	// Opcodes live in instr[15:12]
	localparam opcodeT OP_ADD   = 4'd0;
	localparam opcodeT OP_SUB   = 4'd1;
	localparam opcodeT OP_AND   = 4'd2;
	localparam opcodeT OP_OR    = 4'd3;
	localparam opcodeT OP_XOR   = 4'd4;
	localparam opcodeT OP_MOVI  = 4'd5;
	localparam opcodeT OP_ADDI  = 4'd6;
	localparam opcodeT OP_STORE = 4'd8;
	localparam opcodeT OP_LOAD  = 4'd9;
	localparam opcodeT OP_JUMP  = 4'd10;
	localparam opcodeT OP_BZ    = 4'd11;
	localparam opcodeT OP_BN    = 4'd12;
	localparam opcodeT OP_HALT  = 4'd15;

	localparam instrTypeT TYPE_RTYPE  = 3'b000;
	localparam instrTypeT TYPE_STORE  = 3'b001;
	localparam instrTypeT TYPE_LOAD   = 3'b010;
	localparam instrTypeT TYPE_JUMP   = 3'b011;
	localparam instrTypeT TYPE_BRANCH = 3'b100;
	localparam instrTypeT TYPE_HALT   = 3'b101;
	localparam instrTypeT TYPE_NOP    = 3'b111;

	localparam aluOpT ALU_ADD   = 3'd0;
	localparam aluOpT ALU_SUB   = 3'd1;
	localparam aluOpT ALU_AND   = 3'd2;
	localparam aluOpT ALU_OR    = 3'd3;
	localparam aluOpT ALU_XOR   = 3'd4;
	localparam aluOpT ALU_PASSB = 3'd5;

	typedef enum logic [3:0] {
		Idle,
		Fetch,
		Decode,
		Execute,
		Store,
		Load,
		LoadWrite,
		StoreHold,
		Jump,
		Branch,
		Halt
	} fsmStateT;

endpackage
